//--- hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire busCpuPkg::wordT  yWord,
    input  wire busCpuPkg::wordT  busWord,
    input  wire busCpuPkg::aluOpT aluOp,
    output busCpuPkg::dwordT      aluResult
);

    localparam int w = busCpuPkg::wordBits;

    logic [4:0]         shAmt;
    busCpuPkg::dwordT   yDouble;    // Y twice, used by the rotates
    busCpuPkg::dwordT   rorWide;
    busCpuPkg::dwordT   rolWide;
    logic signed [2*w-1:0] mulA;
    logic signed [2*w-1:0] mulB;
    logic signed [2*w-1:0] product;

    // Single-word result widened into both halves
    function automatic busCpuPkg::dwordT extend(input busCpuPkg::wordT value);
        return {{w{value[w-1]}}, value};
    endfunction

    always_comb begin
        shAmt   = busWord[4:0];
        yDouble = {yWord, yWord};
        rorWide = yDouble >> shAmt;
        rolWide = yDouble << shAmt;
        mulA    = {{w{yWord[w-1]}}, yWord};
        mulB    = {{w{busWord[w-1]}}, busWord};
        product = mulA * mulB;      // Low 64 bits are the signed product
    end

    always_comb begin
        case (aluOp)
            busCpuPkg::opAdd:   aluResult = extend(yWord + busWord);
            busCpuPkg::opSub:   aluResult = extend(yWord - busWord);
            busCpuPkg::opAnd:   aluResult = extend(yWord & busWord);
            busCpuPkg::opOr:    aluResult = extend(yWord | busWord);
            busCpuPkg::opShr:   aluResult = extend(yWord >> shAmt);
            busCpuPkg::opShra:  aluResult = extend($signed(yWord) >>> shAmt);
            busCpuPkg::opShl:   aluResult = extend(yWord << shAmt);
            busCpuPkg::opRor:   aluResult = extend(rorWide[w-1:0]);
            busCpuPkg::opRol:   aluResult = extend(rolWide[2*w-1:w]);
            // Unary ops work on the bus operand
            busCpuPkg::opNeg:   aluResult = extend(-busWord);
            busCpuPkg::opNot:   aluResult = extend(~busWord);
            busCpuPkg::opMul:   aluResult = product;
            busCpuPkg::opIncPc: aluResult = extend(busWord + 1'b1);
            default:            aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/busCpuPkg.sv
`default_nettype none

package busCpuPkg;

    localparam int wordBits = 32;
    localparam int numRegs  = 16;
    localparam int memWords = 512;

    // Instruction field positions
    localparam int raMsb    = 26;        // ra is 26..23
    localparam int rbMsb    = 22;        // rb is 22..19
    localparam int rcMsb    = 18;        // rc is 18..15
    localparam int constMsb = 18;        // Constant is 18..0
    localparam int condLsb  = 19;        // Condition is 20..19

    typedef logic [wordBits-1:0]        wordT;
    typedef logic [2*wordBits-1:0]      dwordT;
    typedef logic [3:0]                 regIdxT;
    typedef logic [numRegs-1:0]         regMaskT;
    typedef logic [$clog2(memWords)-1:0] memAddrT;
    typedef logic [1:0]                 condT;

    // Branch condition codes
    localparam condT condZero    = 2'd0;
    localparam condT condNonzero = 2'd1;
    localparam condT condPos     = 2'd2;
    localparam condT condNeg     = 2'd3;

    typedef enum logic [4:0] {
        opAdd   = 5'd0,
        opSub   = 5'd1,
        opAnd   = 5'd2,
        opOr    = 5'd3,
        opShr   = 5'd4,
        opShra  = 5'd5,
        opShl   = 5'd6,
        opRor   = 5'd7,
        opRol   = 5'd8,
        opNeg   = 5'd9,
        opNot   = 5'd10,
        opMul   = 5'd11,
        opIncPc = 5'd12   // Bus plus one
    } aluOpT;

endpackage

`default_nettype wire

//--- hw/busDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module busDatapath (
    input  wire logic             clk,
    input  wire logic             rstN,
    // Out-enables
    input  wire logic             pcOut,
    input  wire logic             zHighOut,
    input  wire logic             zLowOut,
    input  wire logic             hiOut,
    input  wire logic             loOut,
    input  wire logic             mdrOut,
    input  wire logic             inPortOut,
    input  wire logic             cOut,
    input  wire logic             rOut,
    input  wire logic             baOut,
    // In-enables
    input  wire logic             pcIn,
    input  wire logic             irIn,
    input  wire logic             yIn,
    input  wire logic             zIn,
    input  wire logic             hiIn,
    input  wire logic             loIn,
    input  wire logic             marIn,
    input  wire logic             mdrIn,
    input  wire logic             outPortIn,
    input  wire logic             rIn,
    // Register field selects
    input  wire logic             gra,
    input  wire logic             grb,
    input  wire logic             grc,
    input  wire logic             read,
    input  wire logic             write,
    input  wire logic             conIn,
    input  wire logic             incPc,
    input  wire busCpuPkg::aluOpT aluOp,
    input  wire busCpuPkg::wordT  inPortData,
    output busCpuPkg::wordT       busData,
    output busCpuPkg::wordT       outPortData,
    output logic                  conFlag
);

    busCpuPkg::wordT    pcReg;
    busCpuPkg::wordT    irReg;
    busCpuPkg::wordT    yReg;
    busCpuPkg::wordT    zHighReg;
    busCpuPkg::wordT    zLowReg;
    busCpuPkg::wordT    hiReg;
    busCpuPkg::wordT    loReg;
    busCpuPkg::wordT    inPortReg;

    busCpuPkg::regMaskT regLoad;
    busCpuPkg::regMaskT regRead;
    busCpuPkg::wordT    constWord;
    busCpuPkg::wordT    regWord;
    busCpuPkg::wordT    mdrWord;
    busCpuPkg::aluOpT   aluOpSel;
    busCpuPkg::dwordT   aluResult;

    selectEncode selectEncode_i (
        .irWord    (irReg),
        .gra       (gra),
        .grb       (grb),
        .grc       (grc),
        .rIn       (rIn),
        .rOut      (rOut),
        .baOut     (baOut),
        .regLoad   (regLoad),
        .regRead   (regRead),
        .constWord (constWord)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .busWord (busData),
        .regLoad (regLoad),
        .regRead (regRead),
        .baOut   (baOut),
        .regWord (regWord)
    );

    assign aluOpSel = incPc ? busCpuPkg::opIncPc : aluOp;   // IncPC overrides the op

    aluUnit aluUnit_i (
        .yWord     (yReg),
        .busWord   (busData),
        .aluOp     (aluOpSel),
        .aluResult (aluResult)
    );

    conditionLogic conditionLogic_i (
        .clk     (clk),
        .rstN    (rstN),
        .irWord  (irReg),
        .busWord (busData),
        .conIn   (conIn),
        .conFlag (conFlag)
    );

    memoryUnit memoryUnit_i (
        .clk     (clk),
        .rstN    (rstN),
        .busWord (busData),
        .marIn   (marIn),
        .mdrIn   (mdrIn),
        .read    (read),
        .write   (write),
        .mdrWord (mdrWord)
    );

    // Bus source by fixed priority, zero when idle
    always_comb begin
        if (rOut || baOut)  busData = regWord;
        else if (pcOut)     busData = pcReg;
        else if (zHighOut)  busData = zHighReg;
        else if (zLowOut)   busData = zLowReg;
        else if (hiOut)     busData = hiReg;
        else if (loOut)     busData = loReg;
        else if (mdrOut)    busData = mdrWord;
        else if (inPortOut) busData = inPortReg;
        else if (cOut)      busData = constWord;
        else                busData = '0;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg       <= '0;
            irReg       <= '0;
            yReg        <= '0;
            zHighReg    <= '0;
            zLowReg     <= '0;
            hiReg       <= '0;
            loReg       <= '0;
            inPortReg   <= '0;
            outPortData <= '0;
        end else begin
            inPortReg <= inPortData;    // Sampled every cycle
            if (pcIn) pcReg <= busData;
            if (irIn) irReg <= busData;
            if (yIn)  yReg  <= busData;
            if (zIn) begin
                // Same cycle as the second operand
                zHighReg <= aluResult[2*busCpuPkg::wordBits-1:busCpuPkg::wordBits];
                zLowReg  <= aluResult[busCpuPkg::wordBits-1:0];
            end
            if (hiIn) hiReg <= busData;
            if (loIn) loReg <= busData;
            if (outPortIn) outPortData <= busData;
        end
    end

endmodule

`default_nettype wire

//--- hw/conditionLogic.sv
`timescale 1ns/1ps
`default_nettype none

module conditionLogic (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire busCpuPkg::wordT irWord,
    input  wire busCpuPkg::wordT busWord,
    input  wire logic            conIn,
    output logic                 conFlag
);

    busCpuPkg::condT cond;
    logic            condMet;

    always_comb begin
        cond = irWord[busCpuPkg::condLsb +: $bits(busCpuPkg::condT)];
        case (cond)
            busCpuPkg::condZero:    condMet = (busWord == '0);
            busCpuPkg::condNonzero: condMet = (busWord != '0);
            busCpuPkg::condPos:     condMet = !busWord[busCpuPkg::wordBits-1];
            default:                condMet = busWord[busCpuPkg::wordBits-1];  // Negative
        endcase
    end

    // Flag holds until the next conIn
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= condMet;
        end
    end

endmodule

`default_nettype wire

//--- hw/memoryUnit.sv
`timescale 1ns/1ps
`default_nettype none

module memoryUnit (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire busCpuPkg::wordT busWord,
    input  wire logic            marIn,
    input  wire logic            mdrIn,
    input  wire logic            read,
    input  wire logic            write,
    output busCpuPkg::wordT      mdrWord
);

    busCpuPkg::wordT    mar;
    busCpuPkg::memAddrT memAddr;
    busCpuPkg::wordT    ram [busCpuPkg::memWords];

    assign memAddr = mar[$bits(busCpuPkg::memAddrT)-1:0];   // Upper MAR bits ignored

    // RAM powers up cleared
    initial begin
        for (int i = 0; i < busCpuPkg::memWords; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mar     <= '0;
            mdrWord <= '0;
        end else begin
            if (marIn) mar <= busWord;
            if (mdrIn) mdrWord <= read ? ram[memAddr] : busWord;  // RAM or bus into MDR
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            ram[memAddr] <= mdrWord;
        end
    end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire busCpuPkg::wordT    busWord,
    input  wire busCpuPkg::regMaskT regLoad,
    input  wire busCpuPkg::regMaskT regRead,
    input  wire logic               baOut,
    output busCpuPkg::wordT         regWord
);

    busCpuPkg::wordT regs [busCpuPkg::numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < busCpuPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < busCpuPkg::numRegs; i++) begin
                if (regLoad[i]) begin
                    regs[i] <= busWord;   // One-hot load
                end
            end
        end
    end

    // Read select is one-hot, so OR the picked words together
    always_comb begin
        regWord = '0;
        for (int i = 0; i < busCpuPkg::numRegs; i++) begin
            if (regRead[i]) begin
                regWord = regWord | regs[i];
            end
        end
        // Base address of zero when R0 is the base register
        if (baOut && regRead[0]) begin
            regWord = '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/selectEncode.sv
`timescale 1ns/1ps
`default_nettype none

module selectEncode (
    input  wire busCpuPkg::wordT irWord,
    input  wire logic            gra,
    input  wire logic            grb,
    input  wire logic            grc,
    input  wire logic            rIn,
    input  wire logic            rOut,
    input  wire logic            baOut,
    output busCpuPkg::regMaskT   regLoad,
    output busCpuPkg::regMaskT   regRead,
    output busCpuPkg::wordT      constWord
);

    localparam int idxBits = $bits(busCpuPkg::regIdxT);

    busCpuPkg::regIdxT  regSel;
    busCpuPkg::regMaskT regOneHot;

    // One field at a time, ra wins
    always_comb begin
        if (gra) begin
            regSel = irWord[busCpuPkg::raMsb -: idxBits];
        end else if (grb) begin
            regSel = irWord[busCpuPkg::rbMsb -: idxBits];
        end else if (grc) begin
            regSel = irWord[busCpuPkg::rcMsb -: idxBits];
        end else begin
            regSel = '0;
        end
    end

    always_comb begin
        regOneHot = busCpuPkg::regMaskT'(1) << regSel;
        regLoad   = rIn ? regOneHot : '0;
        // BAout reads like Rout, the R0 rule lives in the register file
        regRead   = (rOut || baOut) ? regOneHot : '0;
    end

    // Sign-extend the 19-bit constant
    assign constWord = {{(busCpuPkg::wordBits - busCpuPkg::constMsb - 1)
                          {irWord[busCpuPkg::constMsb]}},
                        irWord[busCpuPkg::constMsb:0]};

endmodule

`default_nettype wire

//--- list.f
hw/busCpuPkg.sv
hw/selectEncode.sv
hw/regFile.sv
hw/aluUnit.sv
hw/conditionLogic.sv
hw/memoryUnit.sv
hw/busDatapath.sv
tests/busDatapathTb.sv

//--- run.sh
#!/bin/sh
# Build and run the bus datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module busDatapathTb -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VbusDatapathTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
else
    echo "Pass line not found in sim.log"
    exit 1
fi

//--- tests/busDatapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module busDatapathTb;

    logic clk;
    logic rstN;
    logic pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut, rOut, baOut;
    logic pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, rIn;
    logic gra, grb, grc, read, write, conIn, incPc;
    busCpuPkg::aluOpT aluOp;
    busCpuPkg::wordT  inPortData;
    busCpuPkg::wordT  busData;
    busCpuPkg::wordT  outPortData;
    logic             conFlag;

    busCpuPkg::wordT  busSnap;      // Bus value seen late in the last T-state
    busCpuPkg::wordT  memModel [busCpuPkg::memWords];
    int               edgeCount;
    time              edgeTime;
    int               checks;
    int               errors;

    busDatapath busDatapath_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20;
            clk = 1'b1;
            edgeCount++;
            edgeTime = $time;
            #20;
            clk = 1'b0;
        end
    end

    // Expected ALU result with single-word results sign-extended into the high half
    function automatic busCpuPkg::dwordT refAlu(input busCpuPkg::aluOpT op,
                                                input busCpuPkg::wordT y,
                                                input busCpuPkg::wordT b);
        busCpuPkg::wordT r;
        int              n;
        longint          sy;
        longint          sb;
        n  = int'(b[4:0]);
        sy = longint'($signed(y));
        sb = longint'($signed(b));
        case (op)
            busCpuPkg::opAdd:   r = y + b;
            busCpuPkg::opSub:   r = y + ~b + 32'd1;
            busCpuPkg::opAnd:   r = y & b;
            busCpuPkg::opOr:    r = y | b;
            busCpuPkg::opShr:   r = y >> n;
            busCpuPkg::opShra:  r = $signed(y) >>> n;
            busCpuPkg::opShl:   r = y << n;
            busCpuPkg::opRor:   r = (n == 0) ? y : ((y >> n) | (y << (32 - n)));
            busCpuPkg::opRol:   r = (n == 0) ? y : ((y << n) | (y >> (32 - n)));
            busCpuPkg::opNeg:   r = 32'd0 - b;
            busCpuPkg::opNot:   r = ~b;
            busCpuPkg::opMul:   return busCpuPkg::dwordT'(sy * sb);
            busCpuPkg::opIncPc: r = b + 32'd1;
            default:            return '0;
        endcase
        return {{32{r[31]}}, r};
    endfunction

    function automatic logic refCond(input busCpuPkg::condT c, input busCpuPkg::wordT v);
        case (c)
            busCpuPkg::condZero:    return v == 32'd0;
            busCpuPkg::condNonzero: return v != 32'd0;
            busCpuPkg::condPos:     return v[31] == 1'b0;
            default:                return v[31] == 1'b1;
        endcase
    endfunction

    task automatic checkWord(input busCpuPkg::wordT got, input busCpuPkg::wordT exp,
                             input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // Wait for the next rising edge and move 2 ns past it
    task automatic nextEdge(input string where);
        int startCount;
        int waited;
        startCount = edgeCount;
        waited = 0;
        while (edgeCount == startCount && waited < 100) begin
            #1;
            waited++;
        end
        if (edgeCount == startCount) begin
            $display("Timeout: the clock stopped while waiting for %s", where);
            $display("Result: FAILED");
            $finish;
        end else begin
            #(edgeTime + 2 - $time);
        end
    endtask

    task automatic clearStrobes();
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut, rOut, baOut} = '0;
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, rIn} = '0;
        {gra, grb, grc, read, write, conIn, incPc} = '0;
        aluOp = busCpuPkg::opAdd;
    endtask

    // One T-state with one bus source and one destination loading at the edge
    task automatic transfer(input string src, input string dst,
                            input busCpuPkg::aluOpT op = busCpuPkg::opAdd);
        case (src)
            "none":  ;
            "pc":    pcOut = 1'b1;
            "zHigh": zHighOut = 1'b1;
            "zLow":  zLowOut = 1'b1;
            "hi":    hiOut = 1'b1;
            "lo":    loOut = 1'b1;
            "mdr":   mdrOut = 1'b1;
            "in":    inPortOut = 1'b1;
            "const": cOut = 1'b1;
            "ra":    {rOut, gra} = 2'b11;
            "rb":    {rOut, grb} = 2'b11;
            "base":  {baOut, gra} = 2'b11;
            default: begin
                errors++;
                $display("Unknown bus source name %s", src);
            end
        endcase
        case (dst)
            "none":    ;
            "pc":      pcIn = 1'b1;
            "ir":      irIn = 1'b1;
            "y":       yIn = 1'b1;
            "z":       begin
                zIn   = 1'b1;
                aluOp = op;
            end
            "zInc":    {zIn, incPc} = 2'b11;
            "hi":      hiIn = 1'b1;
            "lo":      loIn = 1'b1;
            "mar":     marIn = 1'b1;
            "mdr":     mdrIn = 1'b1;
            "mdrRead": {mdrIn, read} = 2'b11;
            "write":   write = 1'b1;
            "out":     outPortIn = 1'b1;
            "ra":      {rIn, gra} = 2'b11;
            "con":     conIn = 1'b1;
            default: begin
                errors++;
                $display("Unknown transfer destination name %s", dst);
            end
        endcase
        #10 busSnap = busData;     // Bus settled well before the edge
        nextEdge({src, " to ", dst});
        clearStrobes();
    endtask

    // In port samples every cycle and needs one idle state
    task automatic enterWord(input busCpuPkg::wordT w);
        inPortData = w;
        transfer("none", "none");
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("Test %s finished with %0d errors", name, errors - errorsBefore);
    endtask

    task automatic resetValues();
        string srcs[8] = '{"pc", "zHigh", "zLow", "hi", "lo", "mdr", "in", "ra"};
        int    errorsBefore;
        errorsBefore = errors;
        foreach (srcs[i]) begin
            transfer(srcs[i], "none");
            checkWord(busSnap, 32'd0, {srcs[i], " after reset"});
        end
        checkWord(outPortData, 32'd0, "out port after reset");
        checkFlag(conFlag, 1'b0, "CON after reset");
        reportTest("reset values", errorsBefore);
    endtask

    task automatic registerTransfers();
        busCpuPkg::wordT  w;
        busCpuPkg::regIdxT r;
        int               errorsBefore;
        errorsBefore = errors;
        repeat (8) begin
            w = $urandom;
            r = busCpuPkg::regIdxT'($urandom_range(15, 0));
            enterWord({5'd0, r, r, 19'd0});   // ra and rb both name r
            transfer("in", "ir");
            enterWord(w);
            transfer("in", "ra");
            transfer("rb", "out");
            checkWord(busSnap, w, $sformatf("R%0d read back", r));
            checkWord(outPortData, w, "out port");
        end
        enterWord(32'd0);                     // ra is R0
        transfer("in", "ir");
        w = $urandom | 32'h1;
        enterWord(w);
        transfer("in", "ra");
        transfer("base", "none");
        checkWord(busSnap, 32'd0, "BAout with R0");
        transfer("ra", "none");
        checkWord(busSnap, w, "R0 through Rout");
        reportTest("register transfers", errorsBefore);
    endtask

    task automatic aluOperations();
        busCpuPkg::wordT  a;
        busCpuPkg::wordT  b;
        busCpuPkg::aluOpT op;
        busCpuPkg::dwordT expWide;
        int               errorsBefore;
        errorsBefore = errors;
        repeat (40) begin
            a = $urandom;
            b = $urandom;
            for (int k = 0; k < 12; k++) begin
                op = busCpuPkg::aluOpT'(k);
                expWide = refAlu(op, a, b);
                enterWord(a);
                inPortData = b;              // Sampled while a is on the bus
                transfer("in", "y");
                transfer("in", "z", op);
                transfer("zLow", "none");
                checkWord(busSnap, expWide[31:0], $sformatf("%s low", op.name()));
                transfer("zHigh", "none");
                checkWord(busSnap, expWide[63:32], $sformatf("%s high", op.name()));
            end
            enterWord(a);
            transfer("in", "pc");
            transfer("pc", "zInc");
            transfer("zLow", "pc");
            transfer("pc", "none");
            expWide = refAlu(busCpuPkg::opIncPc, 32'd0, a);
            checkWord(busSnap, expWide[31:0], "PC increment");
        end
        reportTest("ALU operations", errorsBefore);
    endtask

    task automatic productMove();
        busCpuPkg::wordT  a;
        busCpuPkg::wordT  b;
        busCpuPkg::dwordT expWide;
        int               errorsBefore;
        errorsBefore = errors;
        repeat (8) begin
            a = $urandom;
            b = $urandom;
            expWide = refAlu(busCpuPkg::opMul, a, b);
            enterWord(a);
            inPortData = b;
            transfer("in", "y");
            transfer("in", "z", busCpuPkg::opMul);
            transfer("zHigh", "hi");
            transfer("zLow", "lo");
            transfer("hi", "none");
            checkWord(busSnap, expWide[63:32], "HI after mul");
            transfer("lo", "none");
            checkWord(busSnap, expWide[31:0], "LO after mul");
        end
        reportTest("product move", errorsBefore);
    endtask

    task automatic memoryAccess();
        busCpuPkg::wordT   marWords [20];
        busCpuPkg::wordT   w;
        busCpuPkg::memAddrT addr;
        int                errorsBefore;
        errorsBefore = errors;
        foreach (memModel[i]) memModel[i] = '0;
        foreach (marWords[i]) marWords[i] = $urandom;   // Upper MAR bits are don't care
        for (int i = 0; i < 16; i++) begin
            w = $urandom;
            addr = marWords[i][8:0];
            memModel[addr] = w;
            enterWord(marWords[i]);
            transfer("in", "mar");
            enterWord(w);
            transfer("in", "mdr");
            transfer("none", "write");
        end
        // Reads of the written words plus four other addresses
        for (int i = 0; i < 20; i++) begin
            addr = marWords[i][8:0];
            enterWord(marWords[i]);
            transfer("in", "mar");
            transfer("none", "mdrRead");
            transfer("mdr", "none");
            checkWord(busSnap, memModel[addr], $sformatf("RAM word %0d", addr));
        end
        reportTest("memory", errorsBefore);
    endtask

    task automatic branchFlag();
        busCpuPkg::wordT   vals [3];
        busCpuPkg::wordT   pcStart;
        busCpuPkg::wordT   ir;
        busCpuPkg::condT   c;
        busCpuPkg::regIdxT r;
        logic              taken;
        int                errorsBefore;
        errorsBefore = errors;
        for (int k = 0; k < 4; k++) begin
            c = busCpuPkg::condT'(k);
            vals = '{32'd0, $urandom & 32'h7fff_ffff | 32'h1, $urandom | 32'h8000_0000};
            foreach (vals[i]) begin
                r = busCpuPkg::regIdxT'($urandom_range(15, 1));
                ir = {5'd0, r, 2'd0, c, 19'($urandom)};
                taken = refCond(c, vals[i]);
                pcStart = $urandom;
                enterWord(ir);
                transfer("in", "ir");
                enterWord(vals[i]);
                transfer("in", "ra");
                transfer("ra", "con");
                checkFlag(conFlag, taken, $sformatf("CON code %0d value %h", c, vals[i]));
                enterWord(pcStart);
                transfer("in", "pc");
                transfer("pc", "y");
                transfer("const", "z", busCpuPkg::opAdd);
                if (conFlag) transfer("zLow", "pc");   // Control unit decision
                transfer("pc", "none");
                checkWord(busSnap, taken ? pcStart + {{13{ir[18]}}, ir[18:0]} : pcStart,
                          $sformatf("PC after branch code %0d", c));
            end
        end
        reportTest("branch", errorsBefore);
    endtask

    initial begin
        void'($urandom(37));
        rstN = 1'b0;
        inPortData = '0;
        clearStrobes();
        checks = 0;
        errors = 0;
        repeat (16) nextEdge("reset");
        rstN = 1'b1;
        resetValues();
        registerTransfers();
        aluOperations();
        productMove();
        memoryAccess();
        branchFlag();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
